// File: common/socket_pkg.sv
/* Single-beat, full-width transfers only. AXI data width equals memory data width,
   ID carries the requester tag plus one source bit in the MSB */

package socket_pkg;

    ////////////////////////////////////////
    // Widths and limits
    ////////////////////////////////////////

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int BYTEEN_W    = DATA_W / 8;
    localparam int TAG_W       = 4;
    localparam int ID_W        = TAG_W + 1;
    localparam int MAX_PENDING = 8;
    localparam int CNT_W       = $clog2(MAX_PENDING + 1);

    typedef logic [ADDR_W-1:0]   mem_addr_t;
    typedef logic [DATA_W-1:0]   mem_data_t;
    typedef logic [BYTEEN_W-1:0] mem_byteen_t;
    typedef logic [TAG_W-1:0]    mem_tag_t;
    typedef logic [ID_W-1:0]     axi_id_t;
    typedef logic [CNT_W-1:0]    pend_cnt_t;

    ////////////////////////////////////////
    // Requester side
    ////////////////////////////////////////

    typedef struct packed {
        mem_addr_t addr;
        mem_tag_t  tag;
    } rd_req_t;

    typedef struct packed {
        logic        rw;
        mem_addr_t   addr;
        mem_byteen_t byteen;
        mem_data_t   data;
        mem_tag_t    tag;
    } mem_req_t;

    typedef struct packed {
        mem_data_t data;
        mem_tag_t  tag;
    } mem_rsp_t;

    ////////////////////////////////////////
    // AXI channels
    ////////////////////////////////////////

    // Shared by AR and AW
    typedef struct packed {
        mem_addr_t addr;
        axi_id_t   id;
    } axi_addr_t;

    typedef struct packed {
        mem_data_t   data;
        mem_byteen_t strb;
    } axi_w_t;

    typedef struct packed {
        mem_data_t data;
        axi_id_t   id;
    } axi_r_t;

    typedef struct packed {
        axi_id_t id;
    } axi_b_t;

endpackage

// File: mem_bridge/mem_read_channel.sv
/* Request to AR and R to response are combinational. At most MAX_PENDING
   reads in flight; R beats must carry the ID that was issued on AR */

`timescale 1ns/1ns

module mem_read_channel (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 req_valid,
    input  socket_pkg::rd_req_t  req,
    output logic                 req_ready,

    output logic                 ar_valid,
    output socket_pkg::axi_addr_t ar,
    input  logic                 ar_ready,

    input  logic                 r_valid,
    input  socket_pkg::axi_r_t   r,
    output logic                 r_ready,

    output logic                 rsp_valid,
    output socket_pkg::mem_rsp_t rsp,
    input  logic                 rsp_ready,

    output logic                 busy
);

    import socket_pkg::*;

    pend_cnt_t pend_cnt;
    logic      pend_full;
    logic      ar_fire;
    logic      rsp_fire;

    assign pend_full = (pend_cnt == pend_cnt_t'(MAX_PENDING));

    // Request side
    assign ar_valid  = req_valid && !pend_full;
    assign ar.addr   = req.addr;
    assign ar.id     = axi_id_t'(req.tag);
    assign req_ready = ar_ready && !pend_full;

    // Response side, tag comes back in the low ID bits
    assign rsp_valid = r_valid;
    assign rsp.data  = r.data;
    assign rsp.tag   = r.id[TAG_W-1:0];
    assign r_ready   = rsp_ready;

    assign ar_fire  = ar_valid && ar_ready;
    assign rsp_fire = r_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_cnt <= '0;
        end else if (ar_fire && !rsp_fire) begin
            pend_cnt <= pend_cnt + 1'b1;
        end else if (rsp_fire && !ar_fire) begin
            pend_cnt <= pend_cnt - 1'b1;
        end
    end

    assign busy = (pend_cnt != '0);

endmodule

// File: mem_bridge/dcache_axi_bridge.sv
/* Writes raise AW and W together; each is sent once and the request retires
   when the later one completes. B only retires the write count */

`timescale 1ns/1ns

module dcache_axi_bridge (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    input  socket_pkg::mem_req_t  req,
    output logic                  req_ready,

    output logic                  ar_valid,
    output socket_pkg::axi_addr_t ar,
    input  logic                  ar_ready,

    input  logic                  r_valid,
    input  socket_pkg::axi_r_t    r,
    output logic                  r_ready,

    output logic                  rsp_valid,
    output socket_pkg::mem_rsp_t  rsp,
    input  logic                  rsp_ready,

    output logic                  aw_valid,
    output socket_pkg::axi_addr_t aw,
    input  logic                  aw_ready,

    output logic                  w_valid,
    output socket_pkg::axi_w_t    w,
    input  logic                  w_ready,

    input  logic                  b_valid,
    input  socket_pkg::axi_b_t    b,
    output logic                  b_ready,

    output logic                  busy
);

    import socket_pkg::*;

    rd_req_t   rd_req;
    logic      rd_valid;
    logic      rd_ready;
    logic      rd_busy;

    logic      wr_req;
    logic      aw_done;
    logic      w_done;
    logic      aw_ok;
    logic      w_ok;
    logic      wr_accept;
    logic      wr_full;
    pend_cnt_t wr_cnt;

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    assign rd_valid    = req_valid && !req.rw;
    assign rd_req.addr = req.addr;
    assign rd_req.tag  = req.tag;

    mem_read_channel u_rd_chan (
        .clk       (clk),
        .rst       (rst),
        .req_valid (rd_valid),
        .req       (rd_req),
        .req_ready (rd_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .busy      (rd_busy)
    );

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    assign wr_req  = req_valid && req.rw;
    assign wr_full = (wr_cnt == pend_cnt_t'(MAX_PENDING));

    assign aw_valid = wr_req && !wr_full && !aw_done;
    assign w_valid  = wr_req && !wr_full && !w_done;

    // Write IDs carry the data-side source bit
    assign aw.addr = req.addr;
    assign aw.id   = {1'b1, req.tag};
    assign w.data  = req.data;
    assign w.strb  = req.byteen;

    assign aw_ok     = aw_done || (aw_valid && aw_ready);
    assign w_ok      = w_done || (w_valid && w_ready);
    assign wr_accept = wr_req && !wr_full && aw_ok && w_ok;

    assign req_ready = req.rw ? (!wr_full && aw_ok && w_ok) : rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (wr_accept) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            aw_done <= aw_ok;
            w_done  <= w_ok;
        end
    end

    assign b_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
        end else if (wr_accept && !b_valid) begin
            wr_cnt <= wr_cnt + 1'b1;
        end else if (b_valid && !wr_accept) begin
            wr_cnt <= wr_cnt - 1'b1;
        end
    end

    assign busy = (wr_cnt != '0) || rd_busy;

endmodule

// File: verilog/axi_read_arb.sv
/* Fixed priority to the instruction side; a stalled AR keeps its grant.
   Source bit lives in the ID MSB and is cleared on the way back */

`timescale 1ns/1ns

module axi_read_arb (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  ic_ar_valid,
    input  socket_pkg::axi_addr_t ic_ar,
    output logic                  ic_ar_ready,

    input  logic                  dc_ar_valid,
    input  socket_pkg::axi_addr_t dc_ar,
    output logic                  dc_ar_ready,

    output logic                  ar_valid,
    output socket_pkg::axi_addr_t ar,
    input  logic                  ar_ready,

    input  logic                  r_valid,
    input  socket_pkg::axi_r_t    r,
    output logic                  r_ready,

    output logic                  ic_r_valid,
    output socket_pkg::axi_r_t    ic_r,
    input  logic                  ic_r_ready,

    output logic                  dc_r_valid,
    output socket_pkg::axi_r_t    dc_r,
    input  logic                  dc_r_ready
);

    import socket_pkg::*;

    logic    locked;
    logic    lock_sel;
    logic    sel;
    axi_id_t src_id;
    logic    r_src;
    axi_r_t  r_clr;

    ////////////////////////////////////////
    // AR grant
    ////////////////////////////////////////

    // 0 selects instruction, 1 selects data
    assign sel = locked ? lock_sel : (!ic_ar_valid && dc_ar_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
        end else if (ar_valid && !ar_ready) begin
            locked   <= 1'b1;
            lock_sel <= sel;
        end else if (ar_valid && ar_ready) begin
            locked   <= 1'b0;
        end
    end

    assign src_id   = sel ? dc_ar.id : ic_ar.id;
    assign ar_valid = sel ? dc_ar_valid : ic_ar_valid;
    assign ar.addr  = sel ? dc_ar.addr : ic_ar.addr;
    assign ar.id    = {sel, src_id[ID_W-2:0]};

    assign ic_ar_ready = !sel && ar_ready;
    assign dc_ar_ready = sel && ar_ready;

    ////////////////////////////////////////
    // R return
    ////////////////////////////////////////

    assign r_src      = r.id[ID_W-1];
    assign r_clr.data = r.data;
    assign r_clr.id   = {1'b0, r.id[ID_W-2:0]};

    assign ic_r_valid = r_valid && !r_src;
    assign dc_r_valid = r_valid && r_src;
    assign ic_r       = r_clr;
    assign dc_r       = r_clr;
    assign r_ready    = r_src ? dc_r_ready : ic_r_ready;

endmodule

// File: verilog/socket_mem_top.sv
/* One AXI bank shared by the instruction and data requesters. Busy stays
   high while any AR or write is outstanding */

`timescale 1ns/1ns

module socket_mem_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  icache_req_valid,
    input  socket_pkg::rd_req_t   icache_req,
    output logic                  icache_req_ready,
    output logic                  icache_rsp_valid,
    output socket_pkg::mem_rsp_t  icache_rsp,
    input  logic                  icache_rsp_ready,

    input  logic                  dcache_req_valid,
    input  socket_pkg::mem_req_t  dcache_req,
    output logic                  dcache_req_ready,
    output logic                  dcache_rsp_valid,
    output socket_pkg::mem_rsp_t  dcache_rsp,
    input  logic                  dcache_rsp_ready,

    output logic                  m_axi_arvalid,
    output socket_pkg::axi_addr_t m_axi_ar,
    input  logic                  m_axi_arready,
    input  logic                  m_axi_rvalid,
    input  socket_pkg::axi_r_t    m_axi_r,
    output logic                  m_axi_rready,

    output logic                  m_axi_awvalid,
    output socket_pkg::axi_addr_t m_axi_aw,
    input  logic                  m_axi_awready,
    output logic                  m_axi_wvalid,
    output socket_pkg::axi_w_t    m_axi_w,
    input  logic                  m_axi_wready,
    input  logic                  m_axi_bvalid,
    input  socket_pkg::axi_b_t    m_axi_b,
    output logic                  m_axi_bready,

    output logic                  busy
);

    import socket_pkg::*;

    logic      ic_ar_valid;
    axi_addr_t ic_ar;
    logic      ic_ar_ready;
    logic      ic_r_valid;
    axi_r_t    ic_r;
    logic      ic_r_ready;
    logic      ic_busy;

    logic      dc_ar_valid;
    axi_addr_t dc_ar;
    logic      dc_ar_ready;
    logic      dc_r_valid;
    axi_r_t    dc_r;
    logic      dc_r_ready;
    logic      dc_busy;

    ////////////////////////////////////////
    // Instruction side
    ////////////////////////////////////////

    mem_read_channel u_icache_rd (
        .clk       (clk),
        .rst       (rst),
        .req_valid (icache_req_valid),
        .req       (icache_req),
        .req_ready (icache_req_ready),
        .ar_valid  (ic_ar_valid),
        .ar        (ic_ar),
        .ar_ready  (ic_ar_ready),
        .r_valid   (ic_r_valid),
        .r         (ic_r),
        .r_ready   (ic_r_ready),
        .rsp_valid (icache_rsp_valid),
        .rsp       (icache_rsp),
        .rsp_ready (icache_rsp_ready),
        .busy      (ic_busy)
    );

    ////////////////////////////////////////
    // Data side, writes go straight out
    ////////////////////////////////////////

    dcache_axi_bridge u_dcache_bridge (
        .clk       (clk),
        .rst       (rst),
        .req_valid (dcache_req_valid),
        .req       (dcache_req),
        .req_ready (dcache_req_ready),
        .ar_valid  (dc_ar_valid),
        .ar        (dc_ar),
        .ar_ready  (dc_ar_ready),
        .r_valid   (dc_r_valid),
        .r         (dc_r),
        .r_ready   (dc_r_ready),
        .rsp_valid (dcache_rsp_valid),
        .rsp       (dcache_rsp),
        .rsp_ready (dcache_rsp_ready),
        .aw_valid  (m_axi_awvalid),
        .aw        (m_axi_aw),
        .aw_ready  (m_axi_awready),
        .w_valid   (m_axi_wvalid),
        .w         (m_axi_w),
        .w_ready   (m_axi_wready),
        .b_valid   (m_axi_bvalid),
        .b         (m_axi_b),
        .b_ready   (m_axi_bready),
        .busy      (dc_busy)
    );

    axi_read_arb u_read_arb (
        .clk         (clk),
        .rst         (rst),
        .ic_ar_valid (ic_ar_valid),
        .ic_ar       (ic_ar),
        .ic_ar_ready (ic_ar_ready),
        .dc_ar_valid (dc_ar_valid),
        .dc_ar       (dc_ar),
        .dc_ar_ready (dc_ar_ready),
        .ar_valid    (m_axi_arvalid),
        .ar          (m_axi_ar),
        .ar_ready    (m_axi_arready),
        .r_valid     (m_axi_rvalid),
        .r           (m_axi_r),
        .r_ready     (m_axi_rready),
        .ic_r_valid  (ic_r_valid),
        .ic_r        (ic_r),
        .ic_r_ready  (ic_r_ready),
        .dc_r_valid  (dc_r_valid),
        .dc_r        (dc_r),
        .dc_r_ready  (dc_r_ready)
    );

    // Both inputs come from registered counters
    assign busy = ic_busy | dc_busy;

endmodule

// File: tests/axi_mem_model.sv
/* Sparse AXI slave memory, single-beat only. Ready and response delay are
   random; R and B return in order, unwritten words read as a fill pattern */

`timescale 1ns/1ns

module axi_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arvalid,
    input  socket_pkg::axi_addr_t ar,
    output logic                  arready,
    output logic                  rvalid,
    output socket_pkg::axi_r_t    r,
    input  logic                  rready,
    input  logic                  awvalid,
    input  socket_pkg::axi_addr_t aw,
    output logic                  awready,
    input  logic                  wvalid,
    input  socket_pkg::axi_w_t    w,
    output logic                  wready,
    output logic                  bvalid,
    output socket_pkg::axi_b_t    b,
    input  logic                  bready
);

    import socket_pkg::*;

    mem_data_t   mem [mem_addr_t];
    axi_r_t      r_q [$];
    int          r_due [$];
    axi_addr_t   aw_q [$];
    axi_w_t      w_q [$];
    axi_b_t      b_q [$];
    int          b_due [$];
    int          cyc;
    logic [16:0] lfsr_state;
    axi_addr_t   aw_cur;
    axi_w_t      w_cur;
    axi_r_t      r_new;
    axi_b_t      b_new;
    mem_data_t   word;
    mem_addr_t   key;

    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic next_bit();
        logic bit_out;
        bit_out    = lfsr_state[16];
        lfsr_state = {lfsr_state[15:0], lfsr_state[16] ^ lfsr_state[13]};
        return bit_out;
    endfunction

    function automatic mem_data_t fill_pattern(mem_addr_t a);
        return {32'hC0DE_0000 ^ a, ~a ^ 32'h5A5A_5A5A};
    endfunction

    function automatic int pick_delay();
        logic [1:0] d;
        d[0] = next_bit();
        d[1] = next_bit();
        return int'(d);
    endfunction

    initial begin
        lfsr_state = 17'd83653;
        cyc        = 0;
        arready    = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        rvalid     = 1'b0;
        bvalid     = 1'b0;
        r          = '0;
        b          = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                r_q.delete();
                r_due.delete();
                aw_q.delete();
                w_q.delete();
                b_q.delete();
                b_due.delete();
            end else begin
                cyc = cyc + 1;
                if (rvalid && rready) begin
                    void'(r_q.pop_front());
                    void'(r_due.pop_front());
                end
                if (bvalid && bready) begin
                    void'(b_q.pop_front());
                    void'(b_due.pop_front());
                end
                if (awvalid && awready) aw_q.push_back(aw);
                if (wvalid && wready) w_q.push_back(w);
                // Writes land before any read accepted in the same cycle
                while (aw_q.size() > 0 && w_q.size() > 0) begin
                    aw_cur = aw_q.pop_front();
                    w_cur  = w_q.pop_front();
                    key    = {3'b000, aw_cur.addr[ADDR_W-1:3]};
                    word   = mem.exists(key) ? mem[key] : fill_pattern(aw_cur.addr);
                    for (int i = 0; i < BYTEEN_W; i++) begin
                        if (w_cur.strb[i]) word[i*8 +: 8] = w_cur.data[i*8 +: 8];
                    end
                    mem[key] = word;
                    b_new.id = aw_cur.id;
                    b_q.push_back(b_new);
                    b_due.push_back(cyc + pick_delay());
                end
                if (arvalid && arready) begin
                    key        = {3'b000, ar.addr[ADDR_W-1:3]};
                    r_new.data = mem.exists(key) ? mem[key] : fill_pattern(ar.addr);
                    r_new.id   = ar.id;
                    r_q.push_back(r_new);
                    r_due.push_back(cyc + pick_delay());
                end
            end
            #1;
            arready = !rst && (next_bit() | next_bit());
            awready = !rst && (next_bit() | next_bit());
            wready  = !rst && (next_bit() | next_bit());
            rvalid  = (r_q.size() > 0) && (r_due[0] <= cyc);
            r       = (r_q.size() > 0) ? r_q[0] : '0;
            bvalid  = (b_q.size() > 0) && (b_due[0] <= cyc);
            b       = (b_q.size() > 0) ? b_q[0] : '0;
        end
    end

endmodule

// File: tests/socket_mem_sva.sv
/* Bound into socket_mem_top. Checks AXI request stability under stall
   and that busy is low right after reset */

`timescale 1ns/1ns

module socket_mem_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  m_axi_arvalid,
    input socket_pkg::axi_addr_t m_axi_ar,
    input logic                  m_axi_arready,
    input logic                  m_axi_awvalid,
    input socket_pkg::axi_addr_t m_axi_aw,
    input logic                  m_axi_awready,
    input logic                  m_axi_wvalid,
    input socket_pkg::axi_w_t    m_axi_w,
    input logic                  m_axi_wready,
    input logic                  busy
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_ar))
        else $error("AR dropped or changed while stalled");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_aw))
        else $error("AW dropped or changed while stalled");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_w))
        else $error("W dropped or changed while stalled");

    busy_reset: assert property (@(posedge clk) rst |=> !busy)
        else $error("busy high after reset");

endmodule

bind socket_mem_top socket_mem_sva u_sva (.*);

// File: tests/tb_socket_mem_top.sv
/* Table-driven testbench for socket_mem_top. Expected read data comes from
   a reference memory; responses are matched per port and tag in order */

`timescale 1ns/1ns

module tb_socket_mem_top;

    import socket_pkg::*;

    localparam int ENTRY_BOUND = 60;

    // port 0 instruction, 1 data, 2 both reads in the same cycle,
    // 3 data read with the instruction read one cycle later
    typedef struct packed {
        logic [1:0]  port;
        logic        rw;
        mem_addr_t   addr;
        mem_byteen_t be;
        mem_data_t   data;
        mem_tag_t    tag;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      icache_req_valid;
    rd_req_t   icache_req;
    logic      icache_req_ready;
    logic      icache_rsp_valid;
    mem_rsp_t  icache_rsp;
    logic      icache_rsp_ready;
    logic      dcache_req_valid;
    mem_req_t  dcache_req;
    logic      dcache_req_ready;
    logic      dcache_rsp_valid;
    mem_rsp_t  dcache_rsp;
    logic      dcache_rsp_ready;
    logic      m_axi_arvalid;
    axi_addr_t m_axi_ar;
    logic      m_axi_arready;
    logic      m_axi_rvalid;
    axi_r_t    m_axi_r;
    logic      m_axi_rready;
    logic      m_axi_awvalid;
    axi_addr_t m_axi_aw;
    logic      m_axi_awready;
    logic      m_axi_wvalid;
    axi_w_t    m_axi_w;
    logic      m_axi_wready;
    logic      m_axi_bvalid;
    axi_b_t    m_axi_b;
    logic      m_axi_bready;
    logic      busy;

    entry_t      table_q [$];
    string       name_q [$];
    mem_data_t   ref_mem [mem_addr_t];
    mem_data_t   exp_data [32][$];
    int          exp_idx [32][$];
    logic [16:0] lfsr_state;
    int          cycles;
    int          wr_out;
    logic        prev_acc;
    logic        dual_active;
    logic        ar_seen;
    logic        first_ar_msb;
    int          first_ar_idx;

    socket_mem_top u_dut (.*);

    axi_mem_model u_mem (
        .clk (clk), .rst (rst),
        .arvalid (m_axi_arvalid), .ar (m_axi_ar), .arready (m_axi_arready),
        .rvalid (m_axi_rvalid), .r (m_axi_r), .rready (m_axi_rready),
        .awvalid (m_axi_awvalid), .aw (m_axi_aw), .awready (m_axi_awready),
        .wvalid (m_axi_wvalid), .w (m_axi_w), .wready (m_axi_wready),
        .bvalid (m_axi_bvalid), .b (m_axi_b), .bready (m_axi_bready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic next_bit();
        logic bit_out;
        bit_out    = lfsr_state[16];
        lfsr_state = {lfsr_state[15:0], lfsr_state[16] ^ lfsr_state[13]};
        return bit_out;
    endfunction

    function automatic mem_data_t fill_pattern(mem_addr_t a);
        return {32'hC0DE_0000 ^ a, ~a ^ 32'h5A5A_5A5A};
    endfunction

    function automatic mem_data_t ref_read(mem_addr_t a);
        mem_addr_t key;
        key = {3'b000, a[ADDR_W-1:3]};
        return ref_mem.exists(key) ? ref_mem[key] : fill_pattern(a);
    endfunction

    task automatic ref_write(mem_addr_t a, mem_byteen_t be, mem_data_t d);
        mem_data_t word;
        word = ref_read(a);
        for (int i = 0; i < BYTEEN_W; i++) begin
            if (be[i]) word[i*8 +: 8] = d[i*8 +: 8];
        end
        ref_mem[{3'b000, a[ADDR_W-1:3]}] = word;
    endtask

    function automatic int pending_rsp();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) n = n + exp_data[i].size();
        return n;
    endfunction

    task automatic add_entry(string name, int port, logic rw, mem_addr_t addr,
                             mem_byteen_t be, mem_data_t data, int tag);
        entry_t e;
        e.port = 2'(port);
        e.rw   = rw;
        e.addr = addr;
        e.be   = be;
        e.data = data;
        e.tag  = mem_tag_t'(tag);
        table_q.push_back(e);
        name_q.push_back(name);
    endtask

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////

    task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(int base, mem_rsp_t rsp);
        int        slot;
        int        idx;
        mem_data_t d;
        slot = base + int'(rsp.tag);
        assert (exp_data[slot].size() > 0)
            else report_failure($sformatf("Unexpected response with tag %0d", rsp.tag));
        d   = exp_data[slot].pop_front();
        idx = exp_idx[slot].pop_front();
        assert (rsp.data == d) else report_mismatch(name_q[idx], d, rsp.data);
    endtask

    ////////////////////////////////////////
    // Monitors and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        icache_rsp_ready = next_bit() | next_bit();
        dcache_rsp_ready = next_bit() | next_bit();
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (icache_rsp_valid && icache_rsp_ready) check_rsp(0, icache_rsp);
            if (dcache_rsp_valid && dcache_rsp_ready) check_rsp(16, dcache_rsp);
            if (dcache_req_valid && dcache_req_ready && dcache_req.rw) wr_out = wr_out + 1;
            if (m_axi_bvalid && m_axi_bready) wr_out = wr_out - 1;
            assert (!prev_acc || busy)
                else report_failure("busy low in the cycle after an accepted request");
            prev_acc = (icache_req_valid && icache_req_ready) ||
                       (dcache_req_valid && dcache_req_ready);
            if (dual_active && !ar_seen && m_axi_arvalid && m_axi_arready) begin
                ar_seen = 1'b1;
                assert (m_axi_ar.id[ID_W-1] == first_ar_msb)
                    else report_mismatch({name_q[first_ar_idx], "_ar_msb"},
                                         64'(first_ar_msb), 64'(m_axi_ar.id[ID_W-1]));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > table_q.size() * ENTRY_BOUND + 100) begin
            $display("Timeout after %0d cycles", cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Holds each raised request until accepted
    task automatic issue(logic ic_on, logic dc_on, int ic_lag);
        logic ic_acc;
        logic dc_acc;
        int   lag;
        ic_acc           = !ic_on;
        dc_acc           = !dc_on;
        lag              = ic_lag;
        icache_req_valid = ic_on && (lag == 0);
        dcache_req_valid = dc_on;
        do begin
            @(posedge clk);
            ic_acc = ic_acc || (icache_req_valid && icache_req_ready);
            dc_acc = dc_acc || (dcache_req_valid && dcache_req_ready);
            #1;
            if (lag > 0) lag = lag - 1;
            if (ic_acc) icache_req_valid = 1'b0;
            else if (ic_on && lag == 0) icache_req_valid = 1'b1;
            if (dc_acc) dcache_req_valid = 1'b0;
        end while (!(ic_acc && dc_acc));
    endtask

    task automatic apply_entry(int i);
        entry_t e;
        e = table_q[i];
        icache_req.addr   = e.addr;
        icache_req.tag    = e.tag;
        dcache_req.rw     = e.rw;
        dcache_req.addr   = (e.port >= 2'd2) ? e.addr + 32'd8 : e.addr;
        dcache_req.byteen = e.be;
        dcache_req.data   = e.data;
        dcache_req.tag    = e.tag;
        if (e.port == 2'd0) begin
            exp_data[int'(e.tag)].push_back(ref_read(e.addr));
            exp_idx[int'(e.tag)].push_back(i);
            issue(1'b1, 1'b0, 0);
        end else if (e.port == 2'd1) begin
            if (e.rw) begin
                ref_write(e.addr, e.be, e.data);
            end else begin
                exp_data[16 + int'(e.tag)].push_back(ref_read(e.addr));
                exp_idx[16 + int'(e.tag)].push_back(i);
            end
            issue(1'b0, 1'b1, 0);
        end else begin
            // Drain so neither side has an AR pending
            while (busy) begin
                @(posedge clk);
                #1;
            end
            exp_data[int'(e.tag)].push_back(ref_read(e.addr));
            exp_idx[int'(e.tag)].push_back(i);
            exp_data[16 + int'(e.tag)].push_back(ref_read(dcache_req.addr));
            exp_idx[16 + int'(e.tag)].push_back(i);
            // A late instruction read must not take over a stalled data AR
            first_ar_msb = (e.port == 2'd3);
            first_ar_idx = i;
            dual_active  = 1'b1;
            ar_seen      = 1'b0;
            issue(1'b1, 1'b1, (e.port == 2'd3) ? 1 : 0);
            dual_active  = 1'b0;
        end
    endtask

    initial begin
        lfsr_state       = 17'd83653;
        cycles           = 0;
        wr_out           = 0;
        prev_acc         = 1'b0;
        dual_active      = 1'b0;
        ar_seen          = 1'b0;
        first_ar_msb     = 1'b0;
        first_ar_idx     = 0;
        rst              = 1'b1;
        icache_req_valid = 1'b0;
        icache_req       = '0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = 1'b0;
        dcache_req       = '0;
        dcache_rsp_ready = 1'b0;

        add_entry("ic_rd_0", 0, 1'b0, 32'h1000, 8'h00, 64'd0, 1);
        add_entry("ic_rd_1", 0, 1'b0, 32'h1008, 8'h00, 64'd0, 2);
        add_entry("ic_rd_2", 0, 1'b0, 32'h1010, 8'h00, 64'd0, 3);
        add_entry("ic_rd_3", 0, 1'b0, 32'h1018, 8'h00, 64'd0, 4);
        add_entry("dc_wr_lo", 1, 1'b1, 32'h2000, 8'h0F, 64'h1122_3344_5566_7788, 5);
        add_entry("dc_rd_lo", 1, 1'b0, 32'h2000, 8'h00, 64'd0, 6);
        add_entry("dc_wr_hi", 1, 1'b1, 32'h2000, 8'hF0, 64'hAABB_CCDD_EEFF_0011, 7);
        add_entry("dc_wr_odd", 1, 1'b1, 32'h2008, 8'h81, 64'hDEAD_BEEF_CAFE_F00D, 8);
        add_entry("dc_rd_hi", 1, 1'b0, 32'h2000, 8'h00, 64'd0, 9);
        add_entry("dc_rd_odd", 1, 1'b0, 32'h2008, 8'h00, 64'd0, 10);
        add_entry("dual_rd_0", 2, 1'b0, 32'h3000, 8'h00, 64'd0, 11);
        add_entry("ic_rd_wr", 0, 1'b0, 32'h2008, 8'h00, 64'd0, 12);
        add_entry("dc_wr_mid", 1, 1'b1, 32'h1010, 8'h3C, 64'h0102_0304_0506_0708, 13);
        add_entry("ic_rd_mid", 0, 1'b0, 32'h1010, 8'h00, 64'd0, 14);
        add_entry("dc_rd_mid", 1, 1'b0, 32'h1010, 8'h00, 64'd0, 15);
        add_entry("ic_rd_again", 0, 1'b0, 32'h1000, 8'h00, 64'd0, 1);
        add_entry("dc_rd_far", 1, 1'b0, 32'h4000, 8'h00, 64'd0, 0);
        add_entry("ic_rd_far", 0, 1'b0, 32'h5000, 8'h00, 64'd0, 0);
        add_entry("dual_rd_1", 2, 1'b0, 32'h6000, 8'h00, 64'd0, 3);
        add_entry("late_ic_0", 3, 1'b0, 32'h7000, 8'h00, 64'd0, 2);
        add_entry("late_ic_1", 3, 1'b0, 32'h7010, 8'h00, 64'd0, 5);
        add_entry("late_ic_2", 3, 1'b0, 32'h7020, 8'h00, 64'd0, 6);
        add_entry("late_ic_3", 3, 1'b0, 32'h7030, 8'h00, 64'd0, 9);
        add_entry("late_ic_4", 3, 1'b0, 32'h7040, 8'h00, 64'd0, 12);
        add_entry("late_ic_5", 3, 1'b0, 32'h7050, 8'h00, 64'd0, 14);

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!busy) else report_failure("busy high after reset");

        for (int i = 0; i < table_q.size(); i++) apply_entry(i);

        do begin
            @(posedge clk);
            #2;
        end while (pending_rsp() != 0 || wr_out != 0);
        assert (!busy) else report_failure("busy still high with nothing outstanding");

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: list.f
common/socket_pkg.sv
mem_bridge/mem_read_channel.sv
mem_bridge/dcache_axi_bridge.sv
verilog/axi_read_arb.sv
verilog/socket_mem_top.sv
tests/axi_mem_model.sv
tests/socket_mem_sva.sv
tests/tb_socket_mem_top.sv

// File: run.sh
#!/bin/sh
# Build and run the socket memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_socket_mem_top \
    --Mdir obj_dir \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
